// File: sim/id_stage_cases.txt
// Columns (hex): word pc ack_delay flush fu rs1 rs2 rd imm illegal ctrl_flow compressed
// fu codes: 0 none, 1 alu, 2 branch, 3 load, 4 store
ffb10093 80000000 0 0 1 02 00 01 fffffffb 0 0 0
005201b3 80000004 2 0 1 04 05 03 00000000 0 0 0
123453b7 80000008 0 0 1 00 00 07 12345000 0 0 0
fffff517 8000000c 1 1 1 00 00 0a fffff000 0 0 0
001000ef 80000010 3 0 1 00 00 01 00000800 0 1 0
00408067 80000014 0 0 1 01 00 00 00000004 0 1 0
fe629ce3 80000018 5 0 2 05 06 00 fffffff8 0 1 0
00c4a403 8000001c 1 0 3 09 00 08 0000000c 0 0 0
feb62e23 80000020 0 0 4 0c 0b 00 fffffffc 0 0 0
12345677 80000024 2 0 0 00 00 00 00000000 1 0 0
000012f5 80000028 0 0 1 05 00 05 fffffffd 0 0 1
0000431d 8000002a 1 0 1 00 00 06 00000007 0 0 1
dead852e 8000002c 0 0 1 00 0b 0a 00000000 0 0 1
00009636 8000002e 4 0 1 0c 0d 0c 00000000 0 0 1
0000bffd 80000030 2 1 1 00 00 00 fffffffe 0 1 1
0000c099 80000032 0 0 2 09 00 00 00000006 0 1 1
0000fd75 80000034 3 0 2 0a 00 00 fffffffc 0 1 1
00004690 80000036 0 0 3 0d 00 0c 00000008 0 0 1
0000c3d8 80000038 1 0 4 0f 0e 00 00000004 0 0 1
00008082 8000003a 0 0 0 00 00 00 00000000 1 0 1

// File: verilog.f
common/id_pkg.sv
common/decode_if.sv
decode/compressed_expander.sv
decode/instr_decoder.sv
hdl/issue_register.sv
hdl/id_stage.sv
sim/id_stage_chk.sv
sim/id_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module id_stage_tb \
  -Mdir obj_dir -o id_stage_tb \
  && ./obj_dir/id_stage_tb > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -qx "Everything OK" "$LOG" \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

// File: sim/id_stage_tb.sv
/*
 * Testbench for the decode stage. Reads the cases, drives fetch, acknowledge
 * and flush, and checks every issue output against the expected entry.
 */
`timescale 1ns/10ps

module id_stage_tb import id_pkg::*; ();

  localparam int     CLK_HALF     = 4;
  localparam int     RST_CYCLES   = 16;
  localparam int     NUM_CASES    = 20;
  localparam int     FIELDS       = 12;
  localparam int     ACCEPT_LIMIT = 4;
  localparam int     SEED         = 57512;
  localparam instr_t NOP_WORD     = 32'h0000_0013;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      flush_i;
  logic      fetch_valid_i;
  instr_t    fetch_instr_i;
  xlen_t     fetch_pc_i;
  logic      fetch_ready_o;
  logic      issue_ack_i;
  logic      issue_valid_o;
  fu_t       issue_fu_o;
  reg_addr_t issue_rs1_o;
  reg_addr_t issue_rs2_o;
  reg_addr_t issue_rd_o;
  xlen_t     issue_imm_o;
  xlen_t     issue_pc_o;
  logic      issue_illegal_o;
  logic      is_ctrl_flow_o;
  logic      is_compressed_o;
  instr_t    orig_instr_o;

  // Row layout: word pc delay flush fu rs1 rs2 rd imm illegal ctrl_flow compressed
  xlen_t case_mem [NUM_CASES*FIELDS];
  int    errors       = 0;
  int    pass_count   = 0;
  int    fail_count   = 0;
  int    limit_cycles = 0;

  id_stage i_id_stage (.*);

  always #CLK_HALF clk_i = ~clk_i;

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_fu(input string name, input fu_t exp, input fu_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s expected x%0d, got x%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic close_test(input string label, input int err_before);
    if (errors == err_before) begin
      pass_count++;
      $display("%s: passed", label);
    end else begin
      fail_count++;
      $display("%s: FAILED", label);
    end
  endtask

  // Whole entry against row b of the case table
  task automatic check_entry(input int b);
    check_bit("issue_valid_o", 1'b1, issue_valid_o);
    check_fu("issue_fu_o", case_mem[b + 4][2:0], issue_fu_o);
    check_reg("issue_rs1_o", case_mem[b + 5][4:0], issue_rs1_o);
    check_reg("issue_rs2_o", case_mem[b + 6][4:0], issue_rs2_o);
    check_reg("issue_rd_o", case_mem[b + 7][4:0], issue_rd_o);
    check_word("issue_imm_o", case_mem[b + 8], issue_imm_o);
    check_word("issue_pc_o", case_mem[b + 1], issue_pc_o);
    check_bit("issue_illegal_o", case_mem[b + 9][0], issue_illegal_o);
    check_bit("is_ctrl_flow_o", case_mem[b + 10][0], is_ctrl_flow_o);
    check_bit("is_compressed_o", case_mem[b + 11][0], is_compressed_o);
    check_word("orig_instr_o", case_mem[b], orig_instr_o);
  endtask

  // --------------------------------------------------
  // One case: fetch, hold under back-pressure, then ack or flush
  // --------------------------------------------------
  task automatic run_case(input int idx);
    int b;
    int idle;
    int waited;
    int err_before;
    b          = idx * FIELDS;
    err_before = errors;
    idle       = $urandom_range(3, 0);
    @(posedge clk_i);
    repeat (idle) @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= case_mem[b];
    fetch_pc_i    <= case_mem[b + 1];
    waited = 0;
    @(negedge clk_i);
    while (!fetch_ready_o && waited < ACCEPT_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!fetch_ready_o) begin
      report_error($sformatf("fetch word %h was not accepted within %0d cycles",
                             case_mem[b], ACCEPT_LIMIT));
      @(posedge clk_i);
      fetch_valid_i <= 1'b0;
    end else begin
      // Word is taken at this edge and must show up one cycle later
      @(posedge clk_i);
      fetch_valid_i <= 1'b0;
      @(negedge clk_i);
      check_entry(b);
      for (int i = 0; i < int'(case_mem[b + 2]); i++) begin
        @(posedge clk_i);
        fetch_valid_i <= 1'b1;
        fetch_instr_i <= NOP_WORD;
        @(negedge clk_i);
        check_bit("fetch_ready_o", 1'b0, fetch_ready_o);
        check_entry(b);
      end
      @(posedge clk_i);
      if (case_mem[b + 3][0]) begin
        fetch_valid_i <= 1'b0;
        flush_i       <= 1'b1;
      end else begin
        // Next word waits during the acknowledge and is taken in the same cycle
        fetch_valid_i <= 1'b1;
        fetch_instr_i <= NOP_WORD;
        issue_ack_i   <= 1'b1;
        @(negedge clk_i);
        check_bit("fetch_ready_o", 1'b1, fetch_ready_o);
        @(posedge clk_i);
        fetch_valid_i <= 1'b0;
        @(negedge clk_i);
        check_bit("issue_valid_o", 1'b1, issue_valid_o);
        check_fu("issue_fu_o", FU_ALU, issue_fu_o);
        check_word("orig_instr_o", NOP_WORD, orig_instr_o);
      end
      // Flush or the held acknowledge empties the register at this edge
      @(posedge clk_i);
      flush_i     <= 1'b0;
      issue_ack_i <= 1'b0;
      @(negedge clk_i);
      check_bit("issue_valid_o", 1'b0, issue_valid_o);
    end
    close_test($sformatf("case %0d word %h", idx, case_mem[b]), err_before);
  endtask

  initial begin
    int max_delay;
    int err_before;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    issue_ack_i   = 1'b0;
    void'($urandom(SEED));
    $readmemh("sim/id_stage_cases.txt", case_mem);

    max_delay = 0;
    for (int i = 0; i < NUM_CASES; i++) begin
      if (int'(case_mem[i*FIELDS + 2]) > max_delay) begin
        max_delay = int'(case_mem[i*FIELDS + 2]);
      end
    end
    // Reset plus the idle check on top of the per-case budget
    limit_cycles = NUM_CASES * (max_delay + 8) + RST_CYCLES + 4;

    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    err_before = errors;
    @(negedge clk_i);
    check_bit("issue_valid_o", 1'b0, issue_valid_o);
    check_bit("fetch_ready_o", 1'b0, fetch_ready_o);
    check_fu("issue_fu_o", FU_NONE, issue_fu_o);
    check_word("issue_imm_o", '0, issue_imm_o);
    check_word("orig_instr_o", '0, orig_instr_o);
    close_test("reset state", err_before);

    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i);
    end

    $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("watchdog: the run did not finish within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

// File: sim/id_stage_chk.sv
/*
 * Handshake and hold assertions for the issue register.
 * Attached to every issue_register instance by the bind at the end.
 */
`timescale 1ns/10ps

module id_stage_chk import id_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      flush_i,
  input logic      fetch_valid_i,
  input logic      fetch_ready_o,
  input logic      issue_ack_i,
  input logic      issue_valid_o,
  input fu_t       issue_fu_o,
  input reg_addr_t issue_rs1_o,
  input reg_addr_t issue_rs2_o,
  input reg_addr_t issue_rd_o,
  input xlen_t     issue_imm_o,
  input xlen_t     issue_pc_o,
  input logic      issue_illegal_o,
  input logic      is_ctrl_flow_o,
  input logic      is_compressed_o,
  input instr_t    orig_instr_o
);

  // Ready is only offered for a word that is there
  a_ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) fetch_ready_o |-> fetch_valid_i
  ) else $error("fetch_ready_o high while fetch_valid_i is low");

  // Back-pressure holds the whole entry
  a_hold_entry: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i && !flush_i |=>
      $stable({issue_valid_o, issue_fu_o, issue_rs1_o, issue_rs2_o, issue_rd_o,
               issue_imm_o, issue_pc_o, issue_illegal_o, is_ctrl_flow_o,
               is_compressed_o, orig_instr_o})
  ) else $error("issue entry changed while stalled");

  a_flush_clears: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_i |=> !issue_valid_o
  ) else $error("issue_valid_o still high in the cycle after a flush");

endmodule

bind issue_register id_stage_chk i_id_stage_chk (.*);

// File: hdl/id_stage.sv
/*
 * Instruction decode stage top level.
 * Fetch word -> RVC expander -> RV32I decoder -> ID/issue register.
 */
`timescale 1ns/10ps

module id_stage import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  // Fetch side
  input  logic      fetch_valid_i,
  input  instr_t    fetch_instr_i,
  input  xlen_t     fetch_pc_i,
  output logic      fetch_ready_o,
  // Issue side
  input  logic      issue_ack_i,
  output logic      issue_valid_o,
  output fu_t       issue_fu_o,
  output reg_addr_t issue_rs1_o,
  output reg_addr_t issue_rs2_o,
  output reg_addr_t issue_rd_o,
  output xlen_t     issue_imm_o,
  output xlen_t     issue_pc_o,
  output logic      issue_illegal_o,
  output logic      is_ctrl_flow_o,
  output logic      is_compressed_o,
  output instr_t    orig_instr_o
);

  instr_t expanded_instr;
  logic   is_compressed;
  logic   cmp_illegal;

  decode_if dec_if ();

  compressed_expander i_compressed_expander (
    .instr_i         (fetch_instr_i),
    .instr_o         (expanded_instr),
    .is_compressed_o (is_compressed),
    .illegal_o       (cmp_illegal)
  );

  instr_decoder i_instr_decoder (
    .instr_i         (expanded_instr),
    .orig_instr_i    (fetch_instr_i),
    .pc_i            (fetch_pc_i),
    .is_compressed_i (is_compressed),
    .illegal_i       (cmp_illegal),
    .dec             (dec_if.producer)
  );

  issue_register i_issue_register (
    .clk_i, .rst_ni, .flush_i, .fetch_valid_i, .fetch_ready_o, .issue_ack_i,
    .dec             (dec_if.consumer),
    .issue_valid_o, .issue_fu_o, .issue_rs1_o, .issue_rs2_o, .issue_rd_o,
    .issue_imm_o, .issue_pc_o, .issue_illegal_o, .is_ctrl_flow_o,
    .is_compressed_o, .orig_instr_o
  );

endmodule

// File: hdl/issue_register.sv
/*
 * ID/issue pipeline register holding a single decoded entry.
 * Takes a new word when empty or when the current entry is acknowledged.
 */
`timescale 1ns/10ps

module issue_register import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      fetch_valid_i,
  output logic      fetch_ready_o,
  input  logic      issue_ack_i,
  decode_if.consumer dec,
  output logic      issue_valid_o,
  output fu_t       issue_fu_o,
  output reg_addr_t issue_rs1_o,
  output reg_addr_t issue_rs2_o,
  output reg_addr_t issue_rd_o,
  output xlen_t     issue_imm_o,
  output xlen_t     issue_pc_o,
  output logic      issue_illegal_o,
  output logic      is_ctrl_flow_o,
  output logic      is_compressed_o,
  output instr_t    orig_instr_o
);

  logic valid_q;

  // Space now, or space freed by this cycle's acknowledge
  assign fetch_ready_o = fetch_valid_i & (~valid_q | issue_ack_i);
  assign issue_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q         <= 1'b0;
      issue_fu_o      <= FU_NONE;
      issue_rs1_o     <= '0;
      issue_rs2_o     <= '0;
      issue_rd_o      <= '0;
      issue_imm_o     <= '0;
      issue_pc_o      <= '0;
      issue_illegal_o <= 1'b0;
      is_ctrl_flow_o  <= 1'b0;
      is_compressed_o <= 1'b0;
      orig_instr_o    <= '0;
    end else begin
      // Flush wins, so a word taken in the flush cycle is dropped
      if (flush_i) begin
        valid_q <= 1'b0;
      end else if (fetch_ready_o) begin
        valid_q <= 1'b1;
      end else if (issue_ack_i) begin
        valid_q <= 1'b0;
      end

      if (fetch_ready_o) begin
        issue_fu_o      <= dec.fu;
        issue_rs1_o     <= dec.rs1;
        issue_rs2_o     <= dec.rs2;
        issue_rd_o      <= dec.rd;
        issue_imm_o     <= dec.imm;
        issue_pc_o      <= dec.pc;
        issue_illegal_o <= dec.illegal;
        is_ctrl_flow_o  <= dec.ctrl_flow;
        is_compressed_o <= dec.is_compressed;
        orig_instr_o    <= dec.orig_instr;
      end
    end
  end

endmodule

// File: decode/instr_decoder.sv
/*
 * Base RV32I decoder: functional unit, register fields, immediate and flags.
 * Combinational; drives the producer side of decode_if.
 */
`timescale 1ns/10ps

module instr_decoder import id_pkg::*; (
  input  instr_t            instr_i,
  input  instr_t            orig_instr_i,
  input  xlen_t             pc_i,
  input  logic              is_compressed_i,
  input  logic              illegal_i,
  decode_if.producer        dec
);

  logic [OPC_WIDTH-1:0] opcode;
  reg_addr_t            rs1_f;
  reg_addr_t            rs2_f;
  reg_addr_t            rd_f;

  xlen_t                imm_i;
  xlen_t                imm_s;
  xlen_t                imm_b;
  xlen_t                imm_u;
  xlen_t                imm_j;

  fu_t                  fu;
  reg_addr_t            rs1;
  reg_addr_t            rs2;
  reg_addr_t            rd;
  xlen_t                imm;
  logic                 illegal;
  logic                 ctrl_flow;

  // --------------------------------------------------
  // Raw fields
  // --------------------------------------------------
  assign opcode = instr_i[OPC_WIDTH-1:0];
  assign rd_f   = instr_i[11:7];
  assign rs1_f  = instr_i[19:15];
  assign rs2_f  = instr_i[24:20];

  // Sign-extended immediates for each format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // --------------------------------------------------
  // Opcode decode
  // --------------------------------------------------
  always_comb begin
    fu        = FU_NONE;
    rs1       = '0;
    rs2       = '0;
    rd        = '0;
    imm       = '0;
    illegal   = 1'b0;
    ctrl_flow = 1'b0;

    case (opcode)
      OPC_OP_IMM: begin
        fu  = FU_ALU;
        rs1 = rs1_f;
        rd  = rd_f;
        imm = imm_i;
      end
      OPC_OP: begin
        fu  = FU_ALU;
        rs1 = rs1_f;
        rs2 = rs2_f;
        rd  = rd_f;
      end
      OPC_LUI, OPC_AUIPC: begin
        fu  = FU_ALU;
        rd  = rd_f;
        imm = imm_u;
      end
      OPC_JAL: begin
        fu        = FU_ALU;
        rd        = rd_f;
        imm       = imm_j;
        ctrl_flow = 1'b1;
      end
      OPC_JALR: begin
        fu        = FU_ALU;
        rs1       = rs1_f;
        rd        = rd_f;
        imm       = imm_i;
        ctrl_flow = 1'b1;
      end
      OPC_BRANCH: begin
        fu        = FU_BRANCH;
        rs1       = rs1_f;
        rs2       = rs2_f;
        imm       = imm_b;
        ctrl_flow = 1'b1;
      end
      OPC_LOAD: begin
        fu  = FU_LOAD;
        rs1 = rs1_f;
        rd  = rd_f;
        imm = imm_i;
      end
      OPC_STORE: begin
        fu  = FU_STORE;
        rs1 = rs1_f;
        rs2 = rs2_f;
        imm = imm_s;
      end
      default: illegal = 1'b1;
    endcase

    // Illegal words carry no operands at all
    if (illegal || illegal_i) begin
      fu        = FU_NONE;
      rs1       = '0;
      rs2       = '0;
      rd        = '0;
      imm       = '0;
      illegal   = 1'b1;
      ctrl_flow = 1'b0;
    end
  end

  assign dec.fu            = fu;
  assign dec.rs1           = rs1;
  assign dec.rs2           = rs2;
  assign dec.rd            = rd;
  assign dec.imm           = imm;
  assign dec.illegal       = illegal;
  assign dec.ctrl_flow     = ctrl_flow;
  assign dec.pc            = pc_i;
  assign dec.orig_instr    = orig_instr_i;
  assign dec.is_compressed = is_compressed_i;

endmodule

// File: decode/compressed_expander.sv
/*
 * Expands a subset of RVC into the equivalent RV32I word.
 * Purely combinational; full-width words pass through untouched.
 */
`timescale 1ns/10ps

module compressed_expander import id_pkg::*; (
  input  instr_t instr_i,
  output instr_t instr_o,
  output logic   is_compressed_o,
  output logic   illegal_o
);

  cinstr_t    c;
  logic [2:0] c_funct3;
  reg_addr_t  rs1_p;
  reg_addr_t  rs2_p;

  assign c        = instr_i[15:0];
  assign c_funct3 = c[15:13];

  // Primed registers map onto x8..x15
  assign rs1_p = {C_REG_PREFIX, c[9:7]};
  assign rs2_p = {C_REG_PREFIX, c[4:2]};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    if (is_compressed_o) begin
      // Unsupported until one of the forms below matches
      instr_o   = '0;
      illegal_o = 1'b1;

      case (c[1:0])
        // --------------------------------------------------
        // Quadrant 0: word loads and stores
        // --------------------------------------------------
        C_QUADRANT0: begin
          if (c_funct3 == C_FUNCT3_LW) begin
            instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, FUNCT3_LW, rs2_p, OPC_LOAD};
            illegal_o = 1'b0;
          end else if (c_funct3 == C_FUNCT3_SW) begin
            instr_o   = {5'b0, c[5], c[12], rs2_p, rs1_p, FUNCT3_SW,
                         c[11:10], c[6], 2'b00, OPC_STORE};
            illegal_o = 1'b0;
          end
        end

        // --------------------------------------------------
        // Quadrant 1: immediates, jumps and branches
        // --------------------------------------------------
        C_QUADRANT1: begin
          case (c_funct3)
            C_FUNCT3_ADDI: begin
              instr_o   = {{7{c[12]}}, c[6:2], c[11:7], FUNCT3_ADD, c[11:7], OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            C_FUNCT3_LI: begin
              instr_o   = {{7{c[12]}}, c[6:2], REG_X0, FUNCT3_ADD, c[11:7], OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            C_FUNCT3_J: begin
              // Scrambled offset goes into the JAL immediate layout
              instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           c[12], {8{c[12]}}, REG_X0, OPC_JAL};
              illegal_o = 1'b0;
            end
            C_FUNCT3_BEQZ: begin
              instr_o   = {{4{c[12]}}, c[6:5], c[2], REG_X0, rs1_p, FUNCT3_BEQ,
                           c[11:10], c[4:3], c[12], OPC_BRANCH};
              illegal_o = 1'b0;
            end
            C_FUNCT3_BNEZ: begin
              instr_o   = {{4{c[12]}}, c[6:5], c[2], REG_X0, rs1_p, FUNCT3_BNE,
                           c[11:10], c[4:3], c[12], OPC_BRANCH};
              illegal_o = 1'b0;
            end
            default: begin
            end
          endcase
        end

        // --------------------------------------------------
        // Quadrant 2: register moves and adds
        // --------------------------------------------------
        C_QUADRANT2: begin
          // rs2 of zero selects C.JR, C.JALR or C.EBREAK, none supported
          if (c_funct3 == C_FUNCT3_MV_ADD && c[6:2] != REG_X0) begin
            if (c[12]) begin
              instr_o = {7'b0, c[6:2], c[11:7], FUNCT3_ADD, c[11:7], OPC_OP};
            end else begin
              instr_o = {7'b0, c[6:2], REG_X0, FUNCT3_ADD, c[11:7], OPC_OP};
            end
            illegal_o = 1'b0;
          end
        end

        default: begin
        end
      endcase
    end
  end

endmodule

// File: common/decode_if.sv
/*
 * One decoded instruction, passed from the decoder to the issue register.
 * Qualified by the fetch valid signal, so it carries no valid of its own.
 */
`timescale 1ns/10ps

interface decode_if import id_pkg::*; ();

  fu_t       fu;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  xlen_t     pc;
  logic      illegal;
  logic      ctrl_flow;
  instr_t    orig_instr;
  logic      is_compressed;

  modport producer (output fu, rs1, rs2, rd, imm, pc, illegal, ctrl_flow,
                    orig_instr, is_compressed);

  modport consumer (input fu, rs1, rs2, rd, imm, pc, illegal, ctrl_flow,
                    orig_instr, is_compressed);

endinterface

// File: common/id_pkg.sv
/*
 * Shared widths, types and encodings for the instruction decode stage.
 * Imported by the expander, the decoder, the issue register and the top level.
 */
package id_pkg;

  // --------------------------------------------------
  // Widths and types
  // --------------------------------------------------
  localparam int unsigned XLEN      = 32;
  localparam int unsigned OPC_WIDTH = 7;

  typedef logic [31:0]      instr_t;
  typedef logic [15:0]      cinstr_t;
  typedef logic [XLEN-1:0]  xlen_t;
  typedef logic [4:0]       reg_addr_t;
  typedef logic [2:0]       fu_t;

  // Functional unit codes
  localparam fu_t FU_NONE   = 3'd0;
  localparam fu_t FU_ALU    = 3'd1;
  localparam fu_t FU_BRANCH = 3'd2;
  localparam fu_t FU_LOAD   = 3'd3;
  localparam fu_t FU_STORE  = 3'd4;

  // --------------------------------------------------
  // RV32I major opcodes
  // --------------------------------------------------
  localparam logic [OPC_WIDTH-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPC_WIDTH-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPC_WIDTH-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPC_WIDTH-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPC_WIDTH-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPC_WIDTH-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPC_WIDTH-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPC_WIDTH-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPC_WIDTH-1:0] OPC_STORE  = 7'b0100011;

  // funct3 of the 32-bit forms built by the expander
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_BEQ = 3'b000;
  localparam logic [2:0] FUNCT3_BNE = 3'b001;
  localparam logic [2:0] FUNCT3_LW  = 3'b010;
  localparam logic [2:0] FUNCT3_SW  = 3'b010;

  localparam reg_addr_t REG_X0 = 5'd0;

  // --------------------------------------------------
  // Compressed encodings
  // --------------------------------------------------
  localparam logic [1:0] C_QUADRANT0 = 2'b00;
  localparam logic [1:0] C_QUADRANT1 = 2'b01;
  localparam logic [1:0] C_QUADRANT2 = 2'b10;

  // Upper two bits of the x8..x15 registers named by 3-bit fields
  localparam logic [1:0] C_REG_PREFIX = 2'b01;

  localparam logic [2:0] C_FUNCT3_LW     = 3'b010;  // Quadrant 0
  localparam logic [2:0] C_FUNCT3_SW     = 3'b110;  // Quadrant 0
  localparam logic [2:0] C_FUNCT3_ADDI   = 3'b000;  // Quadrant 1
  localparam logic [2:0] C_FUNCT3_LI     = 3'b010;  // Quadrant 1
  localparam logic [2:0] C_FUNCT3_J      = 3'b101;  // Quadrant 1
  localparam logic [2:0] C_FUNCT3_BEQZ   = 3'b110;  // Quadrant 1
  localparam logic [2:0] C_FUNCT3_BNEZ   = 3'b111;  // Quadrant 1
  localparam logic [2:0] C_FUNCT3_MV_ADD = 3'b100;  // Quadrant 2

endpackage
